//--- agc/agc_gain_offset.sv
`include "agc_defines.svh"

module agc_gain_offset (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  agc_pkg::agc_cfg_s     cfg_i,
    input  agc_pkg::sample_t      sample_i,
    input  logic                  sample_valid_i,
    output agc_pkg::scaled_word_s word_o
);
    import agc_pkg::*;

    dsp_word_t sample_ext;
    dsp_word_t gain_ext;
    dsp_word_t prod_q;
    logic      prod_valid_q;
    dsp_word_t sum_d;
    logic      in_bounds_d;
    dsp_word_t word_q;
    logic      in_bounds_q;
    logic      word_valid_q;

    // sample sign-extends, gain is unsigned so it zero-extends
    assign sample_ext = dsp_word_t'(sample_i);
    assign gain_ext   = dsp_word_t'(cfg_i.gain);

    // stage one valid
    // samples seen while disabled are dropped here
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_valid_q <= 1'b0;
        end else begin
            prod_valid_q <= sample_valid_i & cfg_i.enable;
        end
    end

    // stage one product, the multiplier output register
    always_ff @(posedge clk_i) begin
        prod_q <= sample_ext * gain_ext;
    end

    // stage two adder, offset is sign-extended to the word
    assign sum_d = prod_q + dsp_word_t'(cfg_i.offset);

    // stand-in for the dsp pattern / inverted pattern match
    // in bounds when every bit from the sign down to lsb+3 agrees
    assign in_bounds_d = (&sum_d[`AGC_WORD_W-1:`AGC_LSB+3])
                       | ~(|sum_d[`AGC_WORD_W-1:`AGC_LSB+3]);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= prod_valid_q;
        end
    end

    // stage two word and bounds flag
    always_ff @(posedge clk_i) begin
        word_q      <= sum_d;
        in_bounds_q <= in_bounds_d;
    end

    assign word_o = '{valid: word_valid_q, word: word_q, in_bounds: in_bounds_q};

    // a word only comes out two cycles after a sample went in
    a_valid_latency: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(word_o.valid) |-> $past(sample_valid_i, 2)
    );

endmodule

//--- agc/agc_window_stats.sv
module agc_window_stats (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  agc_pkg::agc_out_s   agc_i,
    input  agc_pkg::count_t     window_len_i,
    output agc_pkg::agc_stats_s stats_o
);
    import agc_pkg::*;

    // samples taken so far in this window
    count_t     sample_cnt;
    // window length held from the first sample of the window
    count_t     len_q;
    count_t     len_eff;
    logic       last;
    count_t     gt_acc;
    count_t     lt_acc;
    sum_t       sumsq_acc;
    count_t     gt_next;
    count_t     lt_next;
    sum_t       sumsq_next;
    agc_stats_s stats_q;

    // a new window picks up the live register value
    assign len_eff = (sample_cnt == '0) ? window_len_i : len_q;
    // zero length acts as a one-sample window
    assign last    = (sample_cnt + count_t'(1)) >= len_eff;

    // totals including the current sample
    assign gt_next    = gt_acc + count_t'(agc_i.gt);
    assign lt_next    = lt_acc + count_t'(agc_i.lt);
    assign sumsq_next = sumsq_acc + sum_t'(agc_i.mag) * sum_t'(agc_i.mag);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sample_cnt <= '0;
            len_q      <= '0;
            gt_acc     <= '0;
            lt_acc     <= '0;
            sumsq_acc  <= '0;
            stats_q    <= '0;
        end else begin
            // done is a single-cycle pulse
            stats_q.done <= 1'b0;
            if (agc_i.valid) begin
                if (sample_cnt == '0) begin
                    len_q <= window_len_i;
                end
                if (last) begin
                    // latch totals and restart the window
                    stats_q    <= '{done: 1'b1, gt_count: gt_next, lt_count: lt_next,
                                    sumsq: sumsq_next};
                    sample_cnt <= '0;
                    gt_acc     <= '0;
                    lt_acc     <= '0;
                    sumsq_acc  <= '0;
                end else begin
                    sample_cnt <= sample_cnt + count_t'(1);
                    gt_acc     <= gt_next;
                    lt_acc     <= lt_next;
                    sumsq_acc  <= sumsq_next;
                end
            end
        end
    end

    assign stats_o = stats_q;

    // mid-window count stays below the held length
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (sample_cnt != '0) |-> (sample_cnt < len_q)
    );

endmodule

//--- agc/saturate_and_scale.sv
`include "agc_defines.svh"

module saturate_and_scale #(
    parameter bit DECOUPLE = 1'b1
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  agc_pkg::scaled_word_s word_i,
    output agc_pkg::agc_out_s     agc_o
);
    import agc_pkg::*;

    // selected input fields
    logic  in_valid;
    // sign of the word
    logic  in_sign;
    logic  in_bounds;
    // the four code bits above the rounding bit
    logic  [3:0] in_base;
    // bit just below the code lsb
    logic  in_sublsb;

    code_t code_d;
    mag_t  mag_d;
    logic  gt_d;
    logic  lt_d;

    logic  out_valid_q;
    code_t code_q;
    mag_t  mag_q;
    logic  gt_q;
    logic  lt_q;

    // rounding needs the bit below the lsb
    if (`AGC_LSB < 1) begin : g_bad_lsb
        $error("AGC_LSB must be at least 1");
    end

    if (DECOUPLE) begin : g_decouple
        // extra register stage, buys distance from the multiplier
        logic       valid_q;
        logic       sign_q;
        logic       bounds_q;
        logic [3:0] base_q;
        logic       sublsb_q;

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= word_i.valid;
            end
        end

        always_ff @(posedge clk_i) begin
            sign_q   <= word_i.word[`AGC_WORD_W-1];
            bounds_q <= word_i.in_bounds;
            base_q   <= word_i.word[`AGC_LSB +: 4];
            sublsb_q <= word_i.word[`AGC_LSB-1];
        end

        assign in_valid  = valid_q;
        assign in_sign   = sign_q;
        assign in_bounds = bounds_q;
        assign in_base   = base_q;
        assign in_sublsb = sublsb_q;
    end else begin : g_direct
        assign in_valid  = word_i.valid;
        assign in_sign   = word_i.word[`AGC_WORD_W-1];
        assign in_bounds = word_i.in_bounds;
        assign in_base   = word_i.word[`AGC_LSB +: 4];
        assign in_sublsb = word_i.word[`AGC_LSB-1];
    end

    always_comb begin
        // top code bit is the inverted sign in offset binary
        code_d[4] = ~in_sign;
        if (!in_bounds) begin
            // saturate, low bits all follow the inverted sign
            code_d[3:0] = {4{~in_sign}};
            mag_d       = 4'd15;
            // overflow always flags one side
            gt_d        = ~in_sign;
            lt_d        = in_sign;
        end else begin
            // convergent rounding without a carry
            // 00 stays 0, 01 10 11 all give 1, so only bit 0 is rederived
            code_d[3:1] = in_base[3:1];
            code_d[0]   = in_base[0] | in_sublsb;
            // symmetric code, magnitude is a conditional bit flip
            mag_d       = in_sign ? ~code_d[3:0] : code_d[3:0];
            gt_d        = ~in_sign & in_base[3];
            lt_d        = in_sign & ~in_base[3];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= in_valid;
        end
    end

    // output register, large fanout toward the beams
    always_ff @(posedge clk_i) begin
        code_q <= code_d;
        mag_q  <= mag_d;
        gt_q   <= gt_d;
        lt_q   <= lt_d;
    end

    assign agc_o = '{valid: out_valid_q, code: code_q, mag: mag_q, gt: gt_q, lt: lt_q};

    a_flags_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        agc_o.valid |-> !(agc_o.gt && agc_o.lt)
    );

    // out-of-bounds word shows up as full magnitude a cycle later
    a_sat_magnitude: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (in_valid && !in_bounds) |=> (agc_o.valid && agc_o.mag == 4'd15)
    );

endmodule

//--- common/agc_defines.svh
`ifndef AGC_DEFINES_SVH
`define AGC_DEFINES_SVH

// datapath widths
`define AGC_SAMPLE_W   12
`define AGC_GAIN_W     16
`define AGC_OFFSET_W   32
`define AGC_WORD_W     48

// word bit that becomes the lowest code bit
// the bit below it is needed for rounding, so this must be 1 or more
`define AGC_LSB        4

// statistics widths
`define AGC_CNT_W      16
`define AGC_SUM_W      32

// axi4-lite register map, byte addresses
`define AGC_AXI_ADDR_W 8
`define AGC_REG_CTRL   8'h00
`define AGC_REG_GAIN   8'h04
`define AGC_REG_OFFSET 8'h08
`define AGC_REG_WINDOW 8'h0C
`define AGC_REG_GT     8'h10
`define AGC_REG_LT     8'h14
`define AGC_REG_SUMSQ  8'h18
`define AGC_REG_STATUS 8'h1C

`endif

//--- common/agc_pkg.sv
`include "agc_defines.svh"

package agc_pkg;

    // plain vector types for the widths that carry a meaning
    typedef logic signed [`AGC_SAMPLE_W-1:0] sample_t;
    typedef logic        [`AGC_GAIN_W-1:0]   gain_t;
    typedef logic signed [`AGC_OFFSET_W-1:0] offset_t;
    typedef logic signed [`AGC_WORD_W-1:0]   dsp_word_t;
    // offset-binary output code
    typedef logic        [4:0]               code_t;
    // symmetric magnitude of the code
    typedef logic        [3:0]               mag_t;
    typedef logic        [`AGC_CNT_W-1:0]    count_t;
    typedef logic        [`AGC_SUM_W-1:0]    sum_t;

    // gain stage to saturator
    typedef struct packed {
        logic      valid;
        dsp_word_t word;
        // upper word bits all equal, as a dsp pattern detector would flag
        logic      in_bounds;
    } scaled_word_s;

    // saturator output, to the statistics and the channel output
    typedef struct packed {
        logic  valid;
        code_t code;
        mag_t  mag;
        logic  gt;
        logic  lt;
    } agc_out_s;

    // register block to pipeline
    typedef struct packed {
        logic    enable;
        gain_t   gain;
        offset_t offset;
        count_t  window_len;
    } agc_cfg_s;

    // window totals back to the register block
    typedef struct packed {
        logic   done;
        count_t gt_count;
        count_t lt_count;
        sum_t   sumsq;
    } agc_stats_s;

endpackage

//--- dv/agc_checker.sv
module agc_checker (
    input  logic              clk_i,
    input  logic              rst_n_i,
    // dut output stream
    input  agc_pkg::agc_out_s agc_i,
    // expected tuple pushed while its valid is high
    input  agc_pkg::agc_out_s exp_i,
    // register read result with its expected value
    input  logic              reg_valid_i,
    input  logic [7:0]        reg_addr_i,
    input  logic [31:0]       reg_got_i,
    input  logic [31:0]       reg_exp_i,
    // axi write and read responses
    input  logic              bvalid_i,
    input  logic              bready_i,
    input  logic [1:0]        bresp_i,
    input  logic              rvalid_i,
    input  logic              rready_i,
    input  logic [1:0]        rresp_i,
    output int                err_count_o,
    output int                check_count_o,
    output int                pending_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import agc_pkg::*;

    // expected outputs in stream order
    agc_out_s exp_q[$];
    agc_out_s want;
    int       errors;
    int       checks;

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(posedge clk_i) begin
        if (rst_n_i && exp_i.valid) begin
            exp_q.push_back(exp_i);
        end
        if (rst_n_i && agc_i.valid) begin
            if (exp_q.size() == 0) begin
                // also catches output from a disabled channel
                $display("%0t: output code %0d arrived with no expected value pending",
                         $time, agc_i.code);
                errors++;
            end else begin
                want = exp_q.pop_front();
                checks++;
                if (agc_i.code != want.code || agc_i.mag != want.mag ||
                    agc_i.gt != want.gt || agc_i.lt != want.lt) begin
                    $display("Fail at %0t: code %0d mag %0d gt %0b lt %0b, expected %0d %0d %0b %0b",
                             $time, agc_i.code, agc_i.mag, agc_i.gt, agc_i.lt,
                             want.code, want.mag, want.gt, want.lt);
                    errors++;
                end
            end
        end
        if (reg_valid_i) begin
            checks++;
            if (reg_got_i != reg_exp_i) begin
                $display("Fail at %0t: register 0x%02h read 0x%08h, expected 0x%08h",
                         $time, reg_addr_i, reg_got_i, reg_exp_i);
                errors++;
            end
        end
        // every response the master takes must be OKAY
        if (rst_n_i && bvalid_i && bready_i) begin
            checks++;
            if (bresp_i != 2'b00) begin
                $display("Fail at %0t: write response 0x%0h, expected OKAY", $time, bresp_i);
                errors++;
            end
        end
        if (rst_n_i && rvalid_i && rready_i) begin
            checks++;
            if (rresp_i != 2'b00) begin
                $display("Fail at %0t: read response 0x%0h, expected OKAY", $time, rresp_i);
                errors++;
            end
        end
    end

    assign err_count_o   = errors;
    assign check_count_o = checks;
    assign pending_o     = exp_q.size();

endmodule

//--- dv/agc_tb.sv
`include "agc_defines.svh"

module agc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import agc_pkg::*;

    // per-wait limit in cycles or polls
    localparam int          TIMEOUT  = 200;
    localparam int          MEM_SIZE = 256;
    localparam logic [31:0] SEED     = 32'h434770b5;

    logic                       clk;
    logic                       rst_n;
    sample_t                    sample;
    logic                       sample_valid;
    logic [`AGC_AXI_ADDR_W-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [31:0]                wdata;
    logic [3:0]                 wstrb;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [`AGC_AXI_ADDR_W-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    logic [31:0]                rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;
    agc_out_s                   agc;

    // expected outputs and register compares toward the checker
    agc_out_s                   exp_item;
    logic                       reg_valid;
    logic [`AGC_AXI_ADDR_W-1:0] reg_addr;
    logic [31:0]                reg_got;
    logic [31:0]                reg_exp;
    int                         err_count;
    int                         check_count;
    int                         pending;

    // vector count, then seven words per vector
    logic [31:0] vec_mem [0:MEM_SIZE-1];
    logic [31:0] lcg_state;
    logic [31:0] cur_gain;
    logic [31:0] cur_offset;
    // window totals predicted from the file
    logic [31:0] exp_gt;
    logic [31:0] exp_lt;
    logic [31:0] exp_sumsq;
    agc_out_s    vec_exp;
    int          n_vec;
    int          base;
    int          idx;
    // timeouts and other failures seen by this module
    int          tb_faults;

    agc_channel_top u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .awaddr_i       (awaddr),
        .awvalid_i      (awvalid),
        .awready_o      (awready),
        .wdata_i        (wdata),
        .wstrb_i        (wstrb),
        .wvalid_i       (wvalid),
        .wready_o       (wready),
        .bresp_o        (bresp),
        .bvalid_o       (bvalid),
        .bready_i       (bready),
        .araddr_i       (araddr),
        .arvalid_i      (arvalid),
        .arready_o      (arready),
        .rdata_o        (rdata),
        .rresp_o        (rresp),
        .rvalid_o       (rvalid),
        .rready_i       (rready),
        .agc_o          (agc)
    );

    agc_checker u_chk (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .agc_i         (agc),
        .exp_i         (exp_item),
        .reg_valid_i   (reg_valid),
        .reg_addr_i    (reg_addr),
        .reg_got_i     (reg_got),
        .reg_exp_i     (reg_exp),
        .bvalid_i      (bvalid),
        .bready_i      (bready),
        .bresp_i       (bresp),
        .rvalid_i      (rvalid),
        .rready_i      (rready),
        .rresp_i       (rresp),
        .err_count_o   (err_count),
        .check_count_o (check_count),
        .pending_o     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // inputs always change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic note_fault(input string msg);
        $display("%0t: %s", $time, msg);
        tb_faults++;
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int cnt;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        cnt     = 0;
        // ready is state driven, so a high ready here means a handshake at the next edge
        while (!(awready && wready) && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (cnt == TIMEOUT) note_fault("write address and data were never accepted");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cnt     = 0;
        while (!bvalid && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (cnt == TIMEOUT) note_fault("write response never arrived");
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int cnt;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        cnt     = 0;
        while (!arready && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (cnt == TIMEOUT) note_fault("read address was never accepted");
        next_cycle();
        arvalid = 1'b0;
        cnt     = 0;
        while (!rvalid && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (cnt == TIMEOUT) note_fault("read data never arrived");
        data = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    // read a register and hand the pair to the checker
    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        axi_read(addr, got);
        reg_addr  = addr;
        reg_got   = got;
        reg_exp   = expected;
        reg_valid = 1'b1;
        next_cycle();
        reg_valid = 1'b0;
    endtask

    task automatic idle_gap();
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[17:16]) next_cycle();
    endtask

    // one sample with its expected tuple pushed in the same cycle
    task automatic send_sample(input sample_t s, input agc_out_s e, input logic push);
        sample       = s;
        sample_valid = 1'b1;
        exp_item     = e;
        exp_item.valid = push;
        next_cycle();
        sample_valid   = 1'b0;
        exp_item.valid = 1'b0;
        idle_gap();
    endtask

    // wait until every pushed sample has come out
    task automatic drain();
        int cnt;
        cnt = 0;
        while (pending != 0 && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        if (cnt == TIMEOUT) note_fault("pipeline did not drain");
    endtask

    task automatic wait_window_done();
        logic [31:0] st;
        int          cnt;
        st  = '0;
        cnt = 0;
        while (st[0] != 1'b1 && cnt < TIMEOUT) begin
            axi_read(`AGC_REG_STATUS, st);
            cnt++;
        end
        if (st[0] != 1'b1) note_fault("window done bit was never set");
    endtask

    initial begin
        rst_n        = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        exp_item     = '0;
        reg_valid    = 1'b0;
        reg_addr     = '0;
        reg_got      = '0;
        reg_exp      = '0;
        vec_exp      = '0;
        lcg_state    = SEED;
        exp_gt       = '0;
        exp_lt       = '0;
        exp_sumsq    = '0;
        tb_faults    = 0;
        $readmemh("dv/agc_tests.txt", vec_mem);
        n_vec = vec_mem[0];
        if (n_vec < 1 || 1 + 7 * n_vec > MEM_SIZE) begin
            note_fault("test file holds no usable vector count");
            n_vec = 0;
        end

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        // gain resets to 1 and offset to 0
        read_check(`AGC_REG_GAIN, 32'd1);
        read_check(`AGC_REG_OFFSET, 32'd0);
        read_check(`AGC_REG_STATUS, 32'd0);
        cur_gain   = 32'd1;
        cur_offset = 32'd0;

        // one window spans the whole vector set
        axi_write(`AGC_REG_WINDOW, 32'(n_vec));
        read_check(`AGC_REG_WINDOW, 32'(n_vec));
        axi_write(`AGC_REG_CTRL, 32'd1);
        read_check(`AGC_REG_CTRL, 32'd1);

        for (idx = 0; idx < n_vec; idx++) begin
            base = 1 + 7 * idx;
            // new gain or offset only once the pipe is empty
            if (vec_mem[base] != cur_gain || vec_mem[base+1] != cur_offset) begin
                drain();
                cur_gain   = vec_mem[base];
                cur_offset = vec_mem[base+1];
                axi_write(`AGC_REG_GAIN, cur_gain);
                axi_write(`AGC_REG_OFFSET, cur_offset);
                read_check(`AGC_REG_GAIN, cur_gain);
                read_check(`AGC_REG_OFFSET, cur_offset);
            end
            vec_exp.code = vec_mem[base+3][4:0];
            vec_exp.mag  = vec_mem[base+4][3:0];
            vec_exp.gt   = vec_mem[base+5][0];
            vec_exp.lt   = vec_mem[base+6][0];
            exp_gt    = exp_gt + 32'(vec_exp.gt);
            exp_lt    = exp_lt + 32'(vec_exp.lt);
            exp_sumsq = exp_sumsq + 32'(vec_exp.mag) * 32'(vec_exp.mag);
            send_sample(vec_mem[base+2][11:0], vec_exp, 1'b1);
        end
        drain();

        // check the window totals and clear the sticky done bit with a write of 1
        wait_window_done();
        read_check(`AGC_REG_GT, exp_gt);
        read_check(`AGC_REG_LT, exp_lt);
        read_check(`AGC_REG_SUMSQ, exp_sumsq);
        axi_write(`AGC_REG_STATUS, 32'd1);
        read_check(`AGC_REG_STATUS, 32'd0);

        // a disabled channel drops samples and the checker flags any output
        axi_write(`AGC_REG_CTRL, 32'd0);
        read_check(`AGC_REG_CTRL, 32'd0);
        repeat (4) begin
            lcg_state = lcg_next(lcg_state);
            send_sample(sample_t'(lcg_state[27:16]), vec_exp, 1'b0);
        end
        // watch long enough for a sample to cross the four-cycle pipeline
        repeat (10) next_cycle();

        if (pending != 0) begin
            note_fault($sformatf("%0d expected outputs never appeared", pending));
        end
        $display("checks %0d, errors %0d, other faults %0d", check_count, err_count, tb_faults);
        if (err_count == 0 && tb_faults == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- dv/agc_tests.txt
// first value is the vector count, then one vector per line, all hex
// gain offset sample code mag gt lt
18
0001 00000000 000 10 0 0 0
0001 00000000 008 11 1 0 0
0001 00000000 010 11 1 0 0
0001 00000000 018 11 1 0 0
0001 00000000 064 16 6 0 0
0001 00000000 07F 17 7 0 0
0001 00000000 080 1F F 1 0
0001 00000000 FFF 0F 0 0 0
0001 00000000 F80 08 7 0 0
0001 00000000 F7F 00 F 0 1
0001 00000000 800 00 F 0 1
0001 00000000 7FF 1F F 1 0
0003 00000000 028 17 7 0 0
0003 00000000 02B 1F F 1 0
0003 00000000 FEC 0C 3 0 0
0002 FFFFFF9C 032 10 0 0 0
0002 FFFFFF9C 064 16 6 0 0
0002 FFFFFF9C 000 09 6 0 0
0002 FFFFFF9C FEC 00 F 0 1
0100 00000040 000 14 4 0 0
0100 00000040 001 1F F 1 0
0100 00000040 FFF 00 F 0 1
0001 00000028 000 13 3 0 0
0001 00000028 FD0 0F 0 0 0

//--- hdl/agc_axil_regs.sv
`include "agc_defines.svh"

module agc_axil_regs (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // write address and data
    input  logic [`AGC_AXI_ADDR_W-1:0] awaddr_i,
    input  logic                       awvalid_i,
    output logic                       awready_o,
    input  logic [31:0]                wdata_i,
    input  logic [3:0]                 wstrb_i,
    input  logic                       wvalid_i,
    output logic                       wready_o,
    // write response
    output logic [1:0]                 bresp_o,
    output logic                       bvalid_o,
    input  logic                       bready_i,
    // read address and data
    input  logic [`AGC_AXI_ADDR_W-1:0] araddr_i,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    output logic [31:0]                rdata_o,
    output logic [1:0]                 rresp_o,
    output logic                       rvalid_o,
    input  logic                       rready_i,
    input  agc_pkg::agc_stats_s        stats_i,
    output agc_pkg::agc_cfg_s          cfg_o
);
    import agc_pkg::*;

    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        wr_hs;
    logic        rd_hs;
    logic [31:0] wr_merged;

    // control registers
    logic    enable_q;
    gain_t   gain_q;
    offset_t offset_q;
    count_t  window_q;
    // latched window totals
    count_t  gt_q;
    count_t  lt_q;
    sum_t    sumsq_q;
    // sticky window done, write 1 to clear
    logic    done_q;

    function automatic logic [31:0] read_mux(input logic [`AGC_AXI_ADDR_W-1:0] addr);
        logic [31:0] v;
        case (addr)
            `AGC_REG_CTRL:   v = 32'(enable_q);
            `AGC_REG_GAIN:   v = 32'(gain_q);
            `AGC_REG_OFFSET: v = offset_q;
            `AGC_REG_WINDOW: v = 32'(window_q);
            `AGC_REG_GT:     v = 32'(gt_q);
            `AGC_REG_LT:     v = 32'(lt_q);
            `AGC_REG_SUMSQ:  v = sumsq_q;
            `AGC_REG_STATUS: v = 32'(done_q);
            default:         v = '0;
        endcase
        return v;
    endfunction

    // address and data are taken together, one write in flight
    assign awready_o = ~bvalid_q;
    assign wready_o  = ~bvalid_q;
    assign wr_hs     = awvalid_i & wvalid_i & ~bvalid_q;
    // one read in flight
    assign arready_o = ~rvalid_q;
    assign rd_hs     = arvalid_i & ~rvalid_q;

    // byte-lane merge of new data over the current value
    always_comb begin
        wr_merged = read_mux(awaddr_i);
        for (int i = 0; i < 4; i++) begin
            if (wstrb_i[i]) begin
                wr_merged[8*i +: 8] = wdata_i[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            enable_q <= 1'b0;
            gain_q   <= gain_t'(1);
            offset_q <= '0;
            window_q <= count_t'(256);
            gt_q     <= '0;
            lt_q     <= '0;
            sumsq_q  <= '0;
            done_q   <= 1'b0;
        end else begin
            // response held until the master takes it
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
            if (wr_hs) begin
                case (awaddr_i)
                    `AGC_REG_CTRL:   enable_q <= wr_merged[0];
                    `AGC_REG_GAIN:   gain_q   <= wr_merged[`AGC_GAIN_W-1:0];
                    `AGC_REG_OFFSET: offset_q <= wr_merged;
                    `AGC_REG_WINDOW: window_q <= wr_merged[`AGC_CNT_W-1:0];
                    default: ;
                endcase
            end
            // new totals on done, and a fresh done beats a clear
            if (stats_i.done) begin
                gt_q    <= stats_i.gt_count;
                lt_q    <= stats_i.lt_count;
                sumsq_q <= stats_i.sumsq;
                done_q  <= 1'b1;
            end else if (wr_hs && awaddr_i == `AGC_REG_STATUS && wstrb_i[0] && wdata_i[0]) begin
                done_q <= 1'b0;
            end
        end
    end

    // read data captured with the address
    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            rdata_q <= read_mux(araddr_i);
        end
    end

    assign bvalid_o = bvalid_q;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    // always OKAY
    assign bresp_o  = 2'b00;
    assign rresp_o  = 2'b00;

    assign cfg_o = '{enable: enable_q, gain: gain_q, offset: offset_q, window_len: window_q};

endmodule

//--- hdl/agc_channel_top.sv
`include "agc_defines.svh"

module agc_channel_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // adc sample stream, no back-pressure
    input  agc_pkg::sample_t           sample_i,
    input  logic                       sample_valid_i,
    // axi4-lite slave
    input  logic [`AGC_AXI_ADDR_W-1:0] awaddr_i,
    input  logic                       awvalid_i,
    output logic                       awready_o,
    input  logic [31:0]                wdata_i,
    input  logic [3:0]                 wstrb_i,
    input  logic                       wvalid_i,
    output logic                       wready_o,
    output logic [1:0]                 bresp_o,
    output logic                       bvalid_o,
    input  logic                       bready_i,
    input  logic [`AGC_AXI_ADDR_W-1:0] araddr_i,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    output logic [31:0]                rdata_o,
    output logic [1:0]                 rresp_o,
    output logic                       rvalid_o,
    input  logic                       rready_i,
    // 5-bit code with magnitude and flags, four cycles after the sample
    output agc_pkg::agc_out_s          agc_o
);
    import agc_pkg::*;

    agc_cfg_s     cfg;
    agc_stats_s   stats;
    scaled_word_s word;

    agc_axil_regs u_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .stats_i   (stats),
        .cfg_o     (cfg)
    );

    // two cycles, multiply then offset add
    agc_gain_offset u_gain (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cfg_i          (cfg),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .word_o         (word)
    );

    // two more cycles with the decoupling stage
    saturate_and_scale #(
        .DECOUPLE (1'b1)
    ) u_sat (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .word_i  (word),
        .agc_o   (agc_o)
    );

    agc_window_stats u_stats (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .agc_i        (agc_o),
        .window_len_i (cfg.window_len),
        .stats_o      (stats)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module agc_tb -o sim_agc

./obj_dir/sim_agc 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- src.f
+incdir+common
common/agc_pkg.sv
agc/agc_gain_offset.sv
agc/saturate_and_scale.sv
agc/agc_window_stats.sv
hdl/agc_axil_regs.sv
hdl/agc_channel_top.sv
dv/agc_checker.sv
dv/agc_tb.sv
